/* Makefile */
# Verilator build and run of the array heap testbench

TOP = arrayHeapTb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* rtl/arrayHeap.sv */
/*
  Array heap top level, controller with its tables and element store
*/
`timescale 1ns/10ps
`default_nettype none

module arrayHeap (
  input  logic            clock,
  input  logic            reset,                 // Asynchronous, active low
  input  heapPkg::actionT action,
  input  heapPkg::arrayT  array,
  input  heapPkg::indexT  index,
  input  heapPkg::dataT   in,
  output heapPkg::dataT   out,
  output heapPkg::errorT  error
);

  tableIf tableBus ();                           // Controller to tables
  storeIf storeBus ();                           // Controller to element memory

  heapControl controller (
    .clock  (clock),
    .reset  (reset),
    .action (action),
    .array  (array),
    .index  (index),
    .in     (in),
    .out    (out),
    .error  (error),
    .tables (tableBus.control),
    .store  (storeBus.control)
  );

  heapTables tableBlock (
    .clock  (clock),
    .reset  (reset),
    .tables (tableBus.tables)
  );

  elementStore storeBlock (
    .clock  (clock),
    .store  (storeBus.store)
  );

endmodule

`default_nettype wire

/* rtl/elementStore.sv */
/*
  Element memory for all arrays with one write port, one read port
  and the search across the selected array
*/
`timescale 1ns/10ps
`default_nettype none

module elementStore (
  input logic    clock,
  storeIf.store  store
);

  heapPkg::dataT memory [heapPkg::Arrays][heapPkg::ArrayLength]; // Fixed blocks per array

  // Write port -------------------------------------
  always_ff @(posedge clock) begin
    if (store.writeEnable) begin
      memory[store.array][store.index] <= store.writeData;
    end
  end

  assign store.readData = memory[store.array][store.index]; // Read port

  // Search -----------------------------------------
  // Later positions override earlier ones, so the last match wins
  always_comb begin
    heapPkg::sizeT position;
    position = '0;                                   // Nothing found
    for (int i = 0; i < heapPkg::ArrayLength; i++) begin
      if (heapPkg::sizeT'(i) < store.searchLimit &&
          memory[store.array][i] == store.searchValue) begin
        position = heapPkg::sizeT'(i + 1);           // 1-based
      end
    end
    store.findResult = position;
  end

endmodule

`default_nettype wire

/* rtl/heapControl.sv */
/*
  Action decode, access checks, update arithmetic and the registered
  out and error responses
*/
`timescale 1ns/10ps
`default_nettype none

module heapControl (
  input  logic            clock,
  input  logic            reset,
  input  heapPkg::actionT action,
  input  heapPkg::arrayT  array,
  input  heapPkg::indexT  index,
  input  heapPkg::dataT   in,
  output heapPkg::dataT   out,
  output heapPkg::errorT  error,
  tableIf.control         tables,
  storeIf.control         store
);

  heapPkg::errorT accessError;                       // Allocated and live check
  logic           outOfBounds;                       // Index at or above size
  logic           isFull;
  logic           isEmpty;
  heapPkg::dataT  updated;                           // Result of the update actions
  heapPkg::dataT  outNext;
  logic           outLoad;
  heapPkg::errorT errorNext;
  logic           errorLoad;                         // Any recognised action

  // Checks -----------------------------------------
  always_comb begin
    if (!tables.allocated) accessError = heapPkg::errNotAllocated;
    else if (!tables.live) accessError = heapPkg::errFreed;
    else                   accessError = heapPkg::errNone;
  end

  assign outOfBounds = {1'b0, index} >= tables.sizeNow;
  assign isFull      = tables.sizeNow == heapPkg::sizeT'(heapPkg::ArrayLength);
  assign isEmpty     = tables.sizeNow == '0;

  // Update arithmetic on the addressed element
  always_comb begin
    case (action)
      heapPkg::add, heapPkg::addAfter:      updated = store.readData + in;
      heapPkg::subtract, heapPkg::subAfter: updated = store.readData - in;
      heapPkg::bitOr:                       updated = store.readData | in;
      heapPkg::bitXor:                      updated = store.readData ^ in;
      default:                              updated = store.readData & in;
    endcase
  end

  assign tables.array      = array;
  assign store.array       = array;
  assign store.searchValue = in;
  assign store.searchLimit = tables.sizeNow;         // find scans live elements only

  // Push writes at the top, pop reads just below it
  always_comb begin
    case (action)
      heapPkg::push: store.index = heapPkg::indexT'(tables.sizeNow);
      heapPkg::pop:  store.index = heapPkg::indexT'(tables.sizeNow - 1'b1);
      default:       store.index = index;
    endcase
  end

  // Action decode ----------------------------------
  always_comb begin
    tables.sizeWrite    = 1'b0;
    tables.sizeNext     = tables.sizeNow;
    tables.allocate     = 1'b0;
    tables.releaseArray = 1'b0;
    tables.clearAll     = 1'b0;
    store.writeEnable   = 1'b0;
    store.writeData     = in;
    outNext             = out;
    outLoad             = 1'b0;
    errorNext           = accessError;               // Most actions check access first
    errorLoad           = 1'b1;

    case (action)
      heapPkg::clearHeap: begin
        tables.clearAll = 1'b1;
        errorNext       = heapPkg::errNone;
      end
      heapPkg::write: if (accessError == heapPkg::errNone) begin
        store.writeEnable = 1'b1;
        tables.sizeWrite  = outOfBounds;             // Grow to cover the index
        tables.sizeNext   = {1'b0, index} + 1'b1;
        outNext           = in;
        outLoad           = 1'b1;
      end
      heapPkg::read: begin
        if (accessError != heapPkg::errNone) errorNext = accessError;
        else if (outOfBounds)                errorNext = heapPkg::errOutOfBounds;
        else begin
          outNext = store.readData;
          outLoad = 1'b1;
        end
      end
      heapPkg::size: if (accessError == heapPkg::errNone) begin
        outNext = heapPkg::dataT'(tables.sizeNow);
        outLoad = 1'b1;
      end
      heapPkg::inc, heapPkg::push: begin
        if (accessError != heapPkg::errNone) errorNext = accessError;
        else if (isFull)                     errorNext = heapPkg::errFull;
        else begin
          tables.sizeWrite  = 1'b1;
          tables.sizeNext   = tables.sizeNow + 1'b1;
          store.writeEnable = (action == heapPkg::push); // Push stores in at old top
        end
      end
      heapPkg::dec, heapPkg::pop: begin
        if (accessError != heapPkg::errNone) errorNext = accessError;
        else if (isEmpty)                    errorNext = heapPkg::errEmpty;
        else begin
          tables.sizeWrite = 1'b1;
          tables.sizeNext  = tables.sizeNow - 1'b1;
          outNext          = store.readData;
          outLoad          = (action == heapPkg::pop);
        end
      end
      heapPkg::find: if (accessError == heapPkg::errNone) begin
        outNext = heapPkg::dataT'(store.findResult);
        outLoad = 1'b1;
      end
      heapPkg::resize: begin
        if (accessError != heapPkg::errNone)         errorNext = accessError;
        else if (in > heapPkg::dataT'(heapPkg::ArrayLength)) errorNext = heapPkg::errTooLarge;
        else begin
          tables.sizeWrite = 1'b1;
          tables.sizeNext  = heapPkg::sizeT'(in);
        end
      end
      heapPkg::alloc: begin                          // Array is chosen here so no access check
        if (!tables.canAllocate) errorNext = heapPkg::errOutOfMemory;
        else begin
          errorNext       = heapPkg::errNone;
          tables.allocate = 1'b1;
          outNext         = heapPkg::dataT'(tables.newArray);
          outLoad         = 1'b1;
        end
      end
      heapPkg::free: tables.releaseArray = (accessError == heapPkg::errNone);
      heapPkg::add, heapPkg::addAfter, heapPkg::subtract, heapPkg::subAfter,
      heapPkg::bitOr, heapPkg::bitXor, heapPkg::bitAnd: begin
        if (accessError != heapPkg::errNone) errorNext = accessError;
        else if (outOfBounds)                errorNext = heapPkg::errOutOfBounds;
        else begin
          store.writeEnable = 1'b1;
          store.writeData   = updated;
          outLoad           = 1'b1;
          outNext = (action == heapPkg::addAfter || action == heapPkg::subAfter) ?
                    store.readData : updated;        // After forms return old value
        end
      end
      default: errorLoad = 1'b0;                     // nop and unknown codes
    endcase
  end

  // Response registers -----------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      out   <= '0;
      error <= heapPkg::errNone;
    end else begin
      if (outLoad)   out   <= outNext;
      if (errorLoad) error <= errorNext;
    end
  end

endmodule

`default_nettype wire

/* rtl/heapIfs.sv */
/*
  tableIf  controller to allocation and size tables
  storeIf  controller to element memory
*/
`timescale 1ns/10ps
`default_nettype none

interface tableIf;
  heapPkg::arrayT array;                         // Selected array
  logic           sizeWrite;                     // Load sizeNext at the edge
  heapPkg::sizeT  sizeNext;
  logic           allocate;                      // Strobe to take newArray
  logic           releaseArray;                  // Strobe to push array on free stack
  logic           clearAll;                      // Strobe to forget allocations
  logic           allocated;                     // Array below the counter
  logic           live;                          // Allocation flag set
  heapPkg::sizeT  sizeNow;
  heapPkg::arrayT newArray;                      // Next array an alloc returns
  logic           canAllocate;

  modport control (
    output array, sizeWrite, sizeNext, allocate, releaseArray, clearAll,
    input  allocated, live, sizeNow, newArray, canAllocate
  );

  modport tables (
    input  array, sizeWrite, sizeNext, allocate, releaseArray, clearAll,
    output allocated, live, sizeNow, newArray, canAllocate
  );
endinterface

interface storeIf;
  heapPkg::arrayT array;
  heapPkg::indexT index;
  logic           writeEnable;
  heapPkg::dataT  writeData;
  heapPkg::dataT  searchValue;                   // Value sought by find
  heapPkg::sizeT  searchLimit;                   // Live elements to scan
  heapPkg::dataT  readData;                      // Element at array and index
  heapPkg::sizeT  findResult;                    // 1-based position or 0

  modport control (
    output array, index, writeEnable, writeData, searchValue, searchLimit,
    input  readData, findResult
  );

  modport store (
    input  array, index, writeEnable, writeData, searchValue, searchLimit,
    output readData, findResult
  );
endinterface

`default_nettype wire

/* rtl/heapPkg.sv */
/*
  Shared sizes, element types, action codes and error codes
  for the array heap
*/
`default_nettype none

package heapPkg;

  // Sizes ------------------------------------------
  localparam int AddressBits = 3;                // Bits in an array number
  localparam int IndexBits   = 3;                // Bits in an element index
  localparam int DataBits    = 16;               // Bits in an element
  localparam int ArrayLength = 8;                // Elements per array
  localparam int Arrays      = 8;                // Arrays in the heap

  typedef logic [AddressBits-1:0] arrayT;        // Array number
  typedef logic [IndexBits-1:0]   indexT;        // Element index
  typedef logic [DataBits-1:0]    dataT;         // Element value
  typedef logic [IndexBits:0]     sizeT;         // Holds 0 to ArrayLength

  // Action codes -----------------------------------
  typedef enum logic [7:0] {
    nop       = 8'd0,                            // Idle
    clearHeap = 8'd1,                            // Forget all allocations
    write     = 8'd2,                            // Write, growing size if needed
    read      = 8'd3,
    size      = 8'd4,
    inc       = 8'd5,                            // Size up by one
    dec       = 8'd6,                            // Size down by one
    find      = 8'd7,                            // Last match, 1-based
    push      = 8'd14,
    pop       = 8'd15,
    resize    = 8'd17,
    alloc     = 8'd18,
    free      = 8'd19,
    add       = 8'd20,                           // Returns new value
    addAfter  = 8'd21,                           // Returns old value
    subtract  = 8'd22,
    subAfter  = 8'd23,                           // Returns old value
    bitOr     = 8'd28,
    bitXor    = 8'd29,
    bitAnd    = 8'd30
  } actionT;

  // Error codes ------------------------------------
  typedef enum logic [3:0] {
    errNone         = 4'd0,
    errNotAllocated = 4'd1,                      // Array number beyond counter
    errFreed        = 4'd2,                      // Array on the free stack
    errOutOfBounds  = 4'd3,                      // Index at or above size
    errEmpty        = 4'd4,
    errFull         = 4'd5,
    errTooLarge     = 4'd6,                      // Resize beyond ArrayLength
    errOutOfMemory  = 4'd7
  } errorT;

endpackage

`default_nettype wire

/* rtl/heapTables.sv */
/*
  Allocation flags, array sizes, free stack and allocation counter
*/
`timescale 1ns/10ps
`default_nettype none

module heapTables (
  input logic         clock,
  input logic         reset,
  tableIf.tables      tables
);

  localparam int TopBits = heapPkg::AddressBits + 1; // Counts 0 to Arrays

  logic               liveFlags [heapPkg::Arrays];   // Set while allocated
  heapPkg::sizeT      sizes     [heapPkg::Arrays];
  heapPkg::arrayT     freeStack [heapPkg::Arrays];   // Freed arrays, last on top
  logic [TopBits-1:0] freeTop;                       // Entries on the free stack
  logic [TopBits-1:0] counter;                       // Arrays ever handed out
  logic               stackEmpty;
  heapPkg::arrayT     stackHead;                     // Most recently freed array

  // Combinational answers --------------------------
  assign stackEmpty = (freeTop == '0);
  assign stackHead  = freeStack[freeTop[heapPkg::AddressBits-1:0] - 1'b1];

  assign tables.allocated   = {1'b0, tables.array} < counter;
  assign tables.live        = liveFlags[tables.array];
  assign tables.sizeNow     = sizes[tables.array];
  assign tables.newArray    = stackEmpty ? counter[heapPkg::AddressBits-1:0] : stackHead;
  assign tables.canAllocate = !stackEmpty || (counter < TopBits'(heapPkg::Arrays));

  // Flags, sizes and pointers ----------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < heapPkg::Arrays; i++) begin
        liveFlags[i] <= 1'b0;
        sizes[i]     <= '0;
      end
      freeTop <= '0;
      counter <= '0;
    end else begin
      if (tables.clearAll) begin                     // Everything unallocated
        freeTop <= '0;
        counter <= '0;
      end
      if (tables.allocate) begin
        if (stackEmpty) counter <= counter + 1'b1;   // Fresh array number
        else            freeTop <= freeTop - 1'b1;   // Reuse last freed
        liveFlags[tables.newArray] <= 1'b1;
        sizes[tables.newArray]     <= '0;            // Starts empty
      end
      if (tables.releaseArray) begin
        freeTop                 <= freeTop + 1'b1;
        liveFlags[tables.array] <= 1'b0;
      end
      if (tables.sizeWrite) begin
        sizes[tables.array] <= tables.sizeNext;
      end
    end
  end

  // Free stack contents
  always_ff @(posedge clock) begin
    if (tables.releaseArray) begin
      freeStack[freeTop[heapPkg::AddressBits-1:0]] <= tables.array;
    end
  end

endmodule

`default_nettype wire

/* src.f */
rtl/heapPkg.sv
rtl/heapIfs.sv
rtl/heapTables.sv
rtl/elementStore.sv
rtl/heapControl.sv
rtl/arrayHeap.sv
verif/arrayHeap_properties.sv
verif/arrayHeapTb.sv

/* verif/arrayHeapTb.sv */
/*
  Directed tests for the array heap covering allocation, access errors,
  element access, stack, updates and search
*/
`timescale 1ns/10ps
`default_nettype none

module arrayHeapTb;

  logic            clock;
  logic            reset;
  heapPkg::actionT action;
  heapPkg::arrayT  array;
  heapPkg::indexT  index;
  heapPkg::dataT   in;
  heapPkg::dataT   out;
  heapPkg::errorT  error;
  int              errors;                       // Mismatches over the run
  int              testStart;                    // Mismatches before the current test
  int              tests;

  arrayHeap UUT (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;                   // 8 ns period
  end

  initial begin                                  // Watchdog
    #50us;
    $display("Timeout, the run did not finish in time");
    $display("Testbench failed");
    $finish;
  end

  // Helpers ----------------------------------------
  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    if (got !== expected) begin
      $display("Error: %s is %h, expected %h", name, got, expected);
      errors++;
    end
  endtask

  // One action for one cycle, sampled after the response edge
  task automatic apply(input heapPkg::actionT act, input heapPkg::arrayT arr,
                       input heapPkg::indexT idx, input heapPkg::dataT value,
                       input heapPkg::errorT expError);
    @(posedge clock);
    action <= act;
    array  <= arr;
    index  <= idx;
    in     <= value;
    @(posedge clock);
    action <= heapPkg::nop;
    @(negedge clock);
    compareValue($sformatf("error after %s", act.name()), error, expError);
  endtask

  task automatic waitForIdle();
    int cycles;
    cycles = 0;
    while (error !== heapPkg::errNone && cycles < 20) begin
      @(negedge clock);
      cycles++;
    end
    if (error !== heapPkg::errNone) begin
      $display("Error code still set twenty cycles after reset");
      errors++;
    end
  endtask

  task automatic finishTest(input string name);
    tests++;
    $display("%s: %0d mismatches", name, errors - testStart);
    testStart = errors;
  endtask

  task automatic freshArray();                   // Empty heap, array 0 allocated
    apply(heapPkg::clearHeap, '0, '0, '0, heapPkg::errNone);
    apply(heapPkg::alloc, '0, '0, '0, heapPkg::errNone);
  endtask

  // Model of the update actions
  function automatic heapPkg::dataT updatedValue(input heapPkg::actionT act,
                                                 input heapPkg::dataT old,
                                                 input heapPkg::dataT operand);
    case (act)
      heapPkg::add, heapPkg::addAfter:      return old + operand;
      heapPkg::subtract, heapPkg::subAfter: return old - operand;
      heapPkg::bitOr:                       return old | operand;
      heapPkg::bitXor:                      return old ^ operand;
      heapPkg::bitAnd:                      return old & operand;
      default:                              return old;  // Element left as it was
    endcase
  endfunction

  // Tests ------------------------------------------
  task automatic testAllocation();
    for (int i = 0; i < 3; i++) begin
      apply(heapPkg::alloc, '0, '0, '0, heapPkg::errNone);
      compareValue("out", out, i);
    end
    apply(heapPkg::free, 3'd1, '0, '0, heapPkg::errNone);
    apply(heapPkg::free, 3'd2, '0, '0, heapPkg::errNone);
    apply(heapPkg::alloc, '0, '0, '0, heapPkg::errNone);
    compareValue("out", out, 2);                 // Last freed comes back first
    apply(heapPkg::alloc, '0, '0, '0, heapPkg::errNone);
    compareValue("out", out, 1);
    apply(heapPkg::free, 3'd2, '0, '0, heapPkg::errNone);
    apply(heapPkg::free, 3'd2, '0, '0, heapPkg::errFreed);
    for (int i = 0; i < 6; i++) begin            // Reuse 2 and then fresh 3 to 7
      apply(heapPkg::alloc, '0, '0, '0, heapPkg::errNone);
      compareValue("out", out, i + 2);
    end
    apply(heapPkg::alloc, '0, '0, '0, heapPkg::errOutOfMemory);
    freshArray();
    compareValue("out", out, 0);
    finishTest("allocation");
  endtask

  task automatic testAccess();
    apply(heapPkg::read, 3'd5, '0, '0, heapPkg::errNotAllocated);
    apply(heapPkg::write, 3'd0, 3'd2, 16'h1234, heapPkg::errNone);
    compareValue("out", out, 16'h1234);
    apply(heapPkg::read, 3'd0, 3'd3, '0, heapPkg::errOutOfBounds); // Index equals size
    compareValue("out", out, 16'h1234);
    finishTest("access errors");
  endtask

  task automatic testElements();
    heapPkg::dataT  values [8];
    logic           written [8];
    int             highest;
    heapPkg::indexT idx;
    written = '{default: 1'b0};
    highest = -1;
    freshArray();
    for (int i = 0; i < 5; i++) begin
      idx = heapPkg::indexT'($urandom % 8);
      values[idx] = heapPkg::dataT'($urandom);
      written[idx] = 1'b1;
      if (int'(idx) > highest) highest = int'(idx);
      apply(heapPkg::write, '0, idx, values[idx], heapPkg::errNone);
    end
    for (int i = 0; i < 8; i++) begin
      if (written[i]) begin
        apply(heapPkg::read, '0, heapPkg::indexT'(i), '0, heapPkg::errNone);
        compareValue($sformatf("out at index %0d", i), out, values[i]);
      end
    end
    apply(heapPkg::size, '0, '0, '0, heapPkg::errNone);
    compareValue("out as size", out, highest + 1);
    apply(heapPkg::resize, '0, '0, 16'd9, heapPkg::errTooLarge);
    apply(heapPkg::resize, '0, '0, 16'd8, heapPkg::errNone);
    apply(heapPkg::inc, '0, '0, '0, heapPkg::errFull);
    apply(heapPkg::dec, '0, '0, '0, heapPkg::errNone);
    apply(heapPkg::size, '0, '0, '0, heapPkg::errNone);
    compareValue("out as size", out, 7);
    apply(heapPkg::resize, '0, '0, 16'd0, heapPkg::errNone);
    apply(heapPkg::dec, '0, '0, '0, heapPkg::errEmpty);
    apply(heapPkg::inc, '0, '0, '0, heapPkg::errNone);
    apply(heapPkg::size, '0, '0, '0, heapPkg::errNone);
    compareValue("out as size", out, 1);
    finishTest("write, read and size");
  endtask

  task automatic testStack();
    heapPkg::dataT values [8];
    freshArray();
    for (int i = 0; i < 8; i++) begin
      values[i] = heapPkg::dataT'($urandom);
      apply(heapPkg::push, '0, '0, values[i], heapPkg::errNone);
    end
    apply(heapPkg::push, '0, '0, 16'h5a5a, heapPkg::errFull);
    for (int i = 7; i >= 0; i--) begin            // Reverse order
      apply(heapPkg::pop, '0, '0, '0, heapPkg::errNone);
      compareValue($sformatf("out on pop %0d", 7 - i), out, values[i]);
    end
    apply(heapPkg::pop, '0, '0, '0, heapPkg::errEmpty);
    finishTest("stack");
  endtask

  task automatic testUpdates();
    heapPkg::actionT ops [7];
    heapPkg::dataT   old;
    heapPkg::dataT   operand;
    heapPkg::dataT   result;
    heapPkg::indexT  idx;
    ops = '{heapPkg::add, heapPkg::addAfter, heapPkg::subtract, heapPkg::subAfter,
            heapPkg::bitOr, heapPkg::bitXor, heapPkg::bitAnd};
    freshArray();
    apply(heapPkg::resize, '0, '0, 16'd8, heapPkg::errNone); // Whole array live
    foreach (ops[k]) begin
      old     = heapPkg::dataT'($urandom);
      operand = heapPkg::dataT'($urandom);
      idx     = heapPkg::indexT'($urandom % 8);
      result  = updatedValue(ops[k], old, operand);
      apply(heapPkg::write, '0, idx, old, heapPkg::errNone);
      apply(ops[k], '0, idx, operand, heapPkg::errNone);
      compareValue($sformatf("out after %s", ops[k].name()), out,
                   (ops[k] == heapPkg::addAfter || ops[k] == heapPkg::subAfter) ?
                   old : result);                // After forms give the old value
      apply(heapPkg::read, '0, idx, '0, heapPkg::errNone);
      compareValue($sformatf("element after %s", ops[k].name()), out, result);
    end
    finishTest("updates");
  endtask

  task automatic testSearch();
    heapPkg::dataT value;
    freshArray();
    for (int i = 0; i < 8; i++) begin
      if (i == 0 || i == 3) value = 16'hbeef;     // Two matches with the last at 3
      else if (i == 7)      value = 16'hcafe;     // Falls outside after resize
      else                  value = 16'h0100 + 16'(i);
      apply(heapPkg::write, '0, heapPkg::indexT'(i), value, heapPkg::errNone);
    end
    apply(heapPkg::resize, '0, '0, 16'd5, heapPkg::errNone);
    apply(heapPkg::find, '0, '0, 16'hbeef, heapPkg::errNone);
    compareValue("out on find", out, 4);
    apply(heapPkg::find, '0, '0, 16'hcafe, heapPkg::errNone);
    compareValue("out on find", out, 0);
    finishTest("search");
  endtask

  // Sequence ---------------------------------------
  initial begin
    void'($urandom(32'h11e5e7a7));
    reset     = 1'b0;
    action    = heapPkg::nop;
    array     = '0;
    index     = '0;
    in        = '0;
    errors    = 0;
    testStart = 0;
    tests     = 0;
    repeat (2) @(posedge clock);                 // Two cycles in reset
    reset <= 1'b1;
    @(negedge clock);
    waitForIdle();
    testAllocation();
    testAccess();
    testElements();
    testStack();
    testUpdates();
    testSearch();
    $display("Tests run %0d, mismatches %0d", tests, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/arrayHeap_properties.sv */
/*
  Assertions on the heap responses and the free stack pointer,
  bound into the top level
*/
`timescale 1ns/10ps
`default_nettype none

module arrayHeap_properties (
  input logic                          clock,
  input logic                          reset,
  input heapPkg::dataT                 out,
  input heapPkg::errorT                error,
  input logic [heapPkg::AddressBits:0] freeTop  // Entries on the free stack
);

  // Reset clears the error code
  errorAfterReset: assert property (@(posedge clock) !reset |-> error == heapPkg::errNone)
    else $error("error code not cleared while in reset");

  // A refused action leaves out alone
  outHoldsOnError: assert property (@(posedge clock) disable iff (!reset)
    error != heapPkg::errNone |-> out == $past(out))
    else $error("out changed by an action that reported an error");

  stackBounded: assert property (@(posedge clock) disable iff (!reset)
    int'(freeTop) <= heapPkg::Arrays)         // One entry per array at most
    else $error("free stack pointer beyond the number of arrays");

endmodule

bind arrayHeap arrayHeap_properties checks (
  .clock   (clock),
  .reset   (reset),
  .out     (out),
  .error   (error),
  .freeTop (tableBlock.freeTop)
);

`default_nettype wire
